//--- files.f
rtl/fe_cfg_pkg.sv
rtl/la_isa_pkg.sv
rtl/fe_pc_gen.sv
rtl/fe_fetch_reg.sv
rtl/fe_predecode.sv
rtl/fe_instr_buffer.sv
rtl/fe_top.sv
bench/fe_top_chk.sv
bench/fe_monitor.sv
bench/tb_fe_top.sv

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_fe_top -f files.f -o tb_fe_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_fe_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- bench/tb_fe_top.sv
module tb_fe_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam fe_cfg_pkg::addr_t RESET_PC = 32'h1c00_0000;
    localparam int BUF_DEPTH   = 4;
    localparam int DEC_CREDITS = 2;
    localparam int MEM_WORDS   = 1024;
    localparam int IDX_W       = $clog2(MEM_WORDS);
    localparam int TIMEOUT_CYC = 3000;

    logic                   clk;
    logic                   rst_n;
    fe_cfg_pkg::pair_data_t imem_rdata = '0;
    logic                   ex_redirect;
    fe_cfg_pkg::addr_t      ex_target;
    logic                   dec_credit = 1'b0;
    logic                   imem_req;
    fe_cfg_pkg::addr_t      imem_addr;
    logic                   dec_valid;
    fe_cfg_pkg::addr_t      dec_pc;
    fe_cfg_pkg::slot_mask_t dec_mask;
    fe_cfg_pkg::instr_t     dec_instr0;
    fe_cfg_pkg::instr_t     dec_instr1;

    fe_cfg_pkg::instr_t mem [MEM_WORDS];
    integer seed;
    int     held = 0;          // transfers decode has not credited back
    logic   give_credit;
    logic   stall_mode = 1'b0;
    logic   stall = 1'b0;
    int     stall_cnt = 0;
    int     checked;
    int     err_cnt;
    int     timeouts;
    logic   timed_out;

    fe_top #(
        .RESET_PC    (RESET_PC),
        .BUF_DEPTH   (BUF_DEPTH),
        .DEC_CREDITS (DEC_CREDITS)
    ) fe_top_inst (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_imem_rdata  (imem_rdata),
        .i_ex_redirect (ex_redirect),
        .i_ex_target   (ex_target),
        .i_dec_credit  (dec_credit),
        .o_imem_req    (imem_req),
        .o_imem_addr   (imem_addr),
        .o_dec_valid   (dec_valid),
        .o_dec_pc      (dec_pc),
        .o_dec_mask    (dec_mask),
        .o_dec_instr0  (dec_instr0),
        .o_dec_instr1  (dec_instr1)
    );

    fe_monitor #(
        .RESET_PC  (RESET_PC),
        .MEM_WORDS (MEM_WORDS)
    ) fe_monitor_inst (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_mem         (mem),
        .i_imem_req    (imem_req),
        .i_imem_addr   (imem_addr),
        .i_ex_redirect (ex_redirect),
        .i_ex_target   (ex_target),
        .i_dec_valid   (dec_valid),
        .i_dec_pc      (dec_pc),
        .i_dec_mask    (dec_mask),
        .i_dec_instr0  (dec_instr0),
        .i_dec_instr1  (dec_instr1),
        .o_checked     (checked),
        .o_err_cnt     (err_cnt)
    );

    bind fe_top fe_top_chk #(.DEC_CREDITS(DEC_CREDITS)) fe_top_chk_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_imem_req   (o_imem_req),
        .i_dec_valid  (o_dec_valid),
        .i_dec_mask   (o_dec_mask),
        .i_dec_credit (i_dec_credit)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////
    // memory and decode models

    // one cycle read latency and no back-pressure
    always @(posedge clk) begin
        if (imem_req) begin
            imem_rdata <= {mem[{imem_addr[IDX_W+1:3], 1'b1}],
                           mem[{imem_addr[IDX_W+1:3], 1'b0}]};
        end
    end

    assign give_credit = !stall && (held > 0);

    always @(posedge clk) begin
        if (!rst_n) begin
            held       <= 0;
            dec_credit <= 1'b0;
        end else begin
            dec_credit <= give_credit;       // one freed slot per cycle
            held       <= held + int'(dec_valid) - int'(give_credit);
        end
    end

    // long holds then short bursts of returned credits
    always @(posedge clk) begin
        if (!stall_mode) begin
            stall <= 1'b0;
        end else if (stall_cnt == 0) begin
            stall     <= !stall;
            stall_cnt <= stall ? 1 + ($random(seed) & 7) : 12 + ($random(seed) & 31);
        end else begin
            stall_cnt <= stall_cnt - 1;
        end
    end

    function automatic fe_cfg_pkg::instr_t make_branch(input int offs, input logic link);
        la_isa_pkg::offs_t o;
        o = la_isa_pkg::offs_t'(offs);
        return {(link ? la_isa_pkg::OPC_BL : la_isa_pkg::OPC_B), o[15:0], o[25:16]};
    endfunction

    task automatic fill_memory();
        int i;
        int offs;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
            if (($random(seed) & 7) == 0) begin    // about one word in eight
                offs = $random(seed) % 24;
                if (offs == 0) begin
                    offs = 5;
                end
                if (i + offs < 0 || i + offs >= MEM_WORDS) begin
                    offs = -offs;
                end
                mem[i] = make_branch(offs, mem[i][0]);
            end
        end
    endtask

    ////////////////////
    // sequencing

    task automatic wait_pairs(input int target);
        int cyc;
        cyc = 0;
        while (checked < target && cyc < TIMEOUT_CYC) begin
            @(posedge clk);
            cyc++;
        end
        if (checked < target) begin
            $display("timeout: pair %0d never reached decode within %0d cycles",
                     checked + 1, TIMEOUT_CYC);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic drive_redirect(input fe_cfg_pkg::addr_t target);
        @(posedge clk);
        ex_target   <= target;
        ex_redirect <= 1'b1;
        @(posedge clk);
        ex_redirect <= 1'b0;
    endtask

    task automatic run_stimulus();
        int i;
        wait_pairs(40);                 // free running stream
        if (timed_out) return;
        stall_mode <= 1'b1;
        wait_pairs(checked + 60);
        if (timed_out) return;
        for (i = 0; i < 10; i++) begin
            wait_pairs(checked + 3 + ($random(seed) & 7));
            if (timed_out) return;
            repeat ($random(seed) & 3) @(posedge clk);
            drive_redirect(RESET_PC + fe_cfg_pkg::addr_t'(($random(seed) & 32'h3ff) * 4));
        end
        stall_mode <= 1'b0;
        wait_pairs(checked + 30);
    endtask

    task automatic finish_run();
        int assert_fails;
        @(negedge clk);     // last compare has settled
        assert_fails = fe_top_inst.fe_top_chk_inst.fail_cnt;
        $display("pairs checked %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 checked, err_cnt, timeouts, assert_fails);
        if (err_cnt == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        seed        = 32'hfb18_df22;
        rst_n       = 1'b0;
        ex_redirect = 1'b0;
        ex_target   = '0;
        timeouts    = 0;
        timed_out   = 1'b0;
        fill_memory();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        run_stimulus();
        finish_run();
    end

endmodule

//--- bench/fe_monitor.sv
module fe_monitor #(
    parameter fe_cfg_pkg::addr_t RESET_PC = 32'h1c00_0000,
    parameter int MEM_WORDS = 1024
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  fe_cfg_pkg::instr_t     i_mem [MEM_WORDS],
    input  logic                   i_imem_req,
    input  fe_cfg_pkg::addr_t      i_imem_addr,
    input  logic                   i_ex_redirect,
    input  fe_cfg_pkg::addr_t      i_ex_target,
    input  logic                   i_dec_valid,
    input  fe_cfg_pkg::addr_t      i_dec_pc,
    input  fe_cfg_pkg::slot_mask_t i_dec_mask,
    input  fe_cfg_pkg::instr_t     i_dec_instr0,
    input  fe_cfg_pkg::instr_t     i_dec_instr1,
    output int                     o_checked,
    output int                     o_err_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDX_W = $clog2(MEM_WORDS);

    fe_cfg_pkg::addr_t      exp_pc = RESET_PC;   // exact pc with bit 2 possibly set
    fe_cfg_pkg::addr_t      ref_pc;
    fe_cfg_pkg::slot_mask_t ref_mask;
    fe_cfg_pkg::instr_t     ref_w0;
    fe_cfg_pkg::instr_t     ref_w1;
    fe_cfg_pkg::addr_t      ref_next;
    logic                   rst_q = 1'b1;        // reset level at the previous edge
    int                     checked_cnt = 0;
    int                     err_cnt = 0;
    int                     errs_now;

    assign o_checked = checked_cnt;
    assign o_err_cnt = err_cnt;

    function automatic logic is_jump(input fe_cfg_pkg::instr_t w);
        return (w[31:26] == la_isa_pkg::OPC_B) || (w[31:26] == la_isa_pkg::OPC_BL);
    endfunction

    // offs26 sits as {offs[15:0], offs[25:16]} in bits 25..0
    function automatic fe_cfg_pkg::addr_t jump_bytes(input fe_cfg_pkg::instr_t w);
        logic signed [25:0] words;
        int                 w_offs;
        words  = {w[9:0], w[25:10]};
        w_offs = int'(words);
        return fe_cfg_pkg::addr_t'(w_offs * 4);
    endfunction

    ////////////////////
    // expected pair for a given fetch pc

    function automatic void ref_pair(
        input  fe_cfg_pkg::addr_t      pc,
        output fe_cfg_pkg::addr_t      pair_pc,
        output fe_cfg_pkg::slot_mask_t mask,
        output fe_cfg_pkg::instr_t     w0,
        output fe_cfg_pkg::instr_t     w1,
        output fe_cfg_pkg::addr_t      next_pc
    );
        pair_pc = {pc[31:3], 3'b000};
        w0      = i_mem[{pair_pc[IDX_W+1:3], 1'b0}];
        w1      = i_mem[{pair_pc[IDX_W+1:3], 1'b1}];
        mask    = pc[2] ? 2'b10 : 2'b11;     // entry at slot 1 drops slot 0
        next_pc = pair_pc + fe_cfg_pkg::PAIR_BYTES;
        if (mask[0] && is_jump(w0)) begin
            mask    = 2'b01;
            next_pc = pair_pc + jump_bytes(w0);
        end else if (is_jump(w1)) begin
            next_pc = pair_pc + 4 + jump_bytes(w1);
        end
    endfunction

    ////////////////////
    // compare

    always @(posedge clk) begin
        errs_now = 0;
        rst_q   <= i_rst_n;
        if (!rst_q && (i_imem_req || i_dec_valid)) begin
            $display("ERR %0t: fetch or decode output active in or right after reset", $time);
            errs_now++;
        end
        if (i_rst_n && i_imem_req && i_imem_addr[2:0] !== 3'b000) begin
            $display("ERR %0t: fetch address %h is not pair aligned", $time, i_imem_addr);
            errs_now++;
        end
        if (i_rst_n && i_dec_valid) begin
            ref_pair(exp_pc, ref_pc, ref_mask, ref_w0, ref_w1, ref_next);
            if (i_dec_pc !== ref_pc || i_dec_mask !== ref_mask ||
                i_dec_instr0 !== ref_w0 || i_dec_instr1 !== ref_w1) begin
                $display("ERR %0t: pair %0d got pc %h mask %b words %h %h", $time,
                         checked_cnt + 1, i_dec_pc, i_dec_mask, i_dec_instr0, i_dec_instr1);
                $display("ERR %0t: pair %0d expected pc %h mask %b words %h %h", $time,
                         checked_cnt + 1, ref_pc, ref_mask, ref_w0, ref_w1);
                errs_now++;
            end
            exp_pc      <= ref_next;
            checked_cnt <= checked_cnt + 1;
        end
        if (!i_rst_n) begin
            exp_pc <= RESET_PC;
        end else if (i_ex_redirect) begin
            exp_pc <= i_ex_target;    // after this cycle's transfer
        end
        err_cnt <= err_cnt + errs_now;
    end

endmodule

//--- bench/fe_top_chk.sv
module fe_top_chk #(
    parameter int DEC_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_imem_req,
    input  logic                   i_dec_valid,
    input  fe_cfg_pkg::slot_mask_t i_dec_mask,
    input  logic                   i_dec_credit
);
    timeunit 1ns;
    timeprecision 1ps;

    int   credits;       // decode slots still free as decode sees them
    logic rst_seen;      // a reset edge has already passed
    int   fail_cnt = 0;  // failed assertions so far

    always @(posedge clk) begin
        if (!i_rst_n) begin
            credits  <= DEC_CREDITS;
            rst_seen <= 1'b1;
        end else begin
            credits  <= credits - int'(i_dec_valid) + int'(i_dec_credit);
            rst_seen <= 1'b0;
        end
    end

    xfer_needs_credit: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_dec_valid |-> credits > 0)
        else begin
            $error("transfer to decode while no decode credit was left");
            fail_cnt++;
        end

    mask_not_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_dec_valid |-> i_dec_mask != '0)
        else begin
            $error("pair handed to decode with no valid slot");
            fail_cnt++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        (!i_rst_n && rst_seen) |-> (!i_imem_req && !i_dec_valid))
        else begin
            $error("fetch request or decode valid raised during reset");
            fail_cnt++;
        end

endmodule

//--- rtl/fe_top.sv
module fe_top #(
    parameter fe_cfg_pkg::addr_t RESET_PC = 32'h1c00_0000,
    parameter int BUF_DEPTH   = 4,
    parameter int DEC_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  fe_cfg_pkg::pair_data_t i_imem_rdata,
    input  logic                   i_ex_redirect,
    input  fe_cfg_pkg::addr_t      i_ex_target,
    input  logic                   i_dec_credit,
    output logic                   o_imem_req,
    output fe_cfg_pkg::addr_t      o_imem_addr,
    output logic                   o_dec_valid,
    output fe_cfg_pkg::addr_t      o_dec_pc,
    output fe_cfg_pkg::slot_mask_t o_dec_mask,
    output fe_cfg_pkg::instr_t     o_dec_instr0,
    output fe_cfg_pkg::instr_t     o_dec_instr1
);

    ////////////////////
    // stage wires

    fe_cfg_pkg::addr_t      fetch_pc;
    logic                   fr_valid;      // fetch register to pre-decoder
    fe_cfg_pkg::addr_t      fr_pc;
    fe_cfg_pkg::slot_mask_t fr_mask;
    logic                   fr_squash;
    logic                   pd_wr;         // pre-decoder to buffer
    fe_cfg_pkg::slot_mask_t pd_mask;
    logic                   pd_redirect;
    fe_cfg_pkg::addr_t      pd_target;
    logic                   pop_credit;

    fe_pc_gen #(
        .RESET_PC  (RESET_PC),
        .BUF_DEPTH (BUF_DEPTH)
    ) fe_pc_gen_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_ex_redirect (i_ex_redirect),
        .i_ex_target   (i_ex_target),
        .i_pd_redirect (pd_redirect),
        .i_pd_target   (pd_target),
        .i_pop_credit  (pop_credit),
        .i_squash      (fr_squash),
        .o_imem_req    (o_imem_req),
        .o_imem_addr   (o_imem_addr),
        .o_fetch_pc    (fetch_pc)
    );

    fe_fetch_reg fe_fetch_reg_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_req         (o_imem_req),
        .i_fetch_pc    (fetch_pc),
        .i_ex_redirect (i_ex_redirect),
        .i_pd_redirect (pd_redirect),
        .o_valid       (fr_valid),
        .o_pc          (fr_pc),
        .o_mask        (fr_mask),
        .o_squash      (fr_squash)
    );

    // memory words line up with the fetch register outputs
    fe_predecode fe_predecode_inst (
        .i_valid    (fr_valid),
        .i_pc       (fr_pc),
        .i_mask     (fr_mask),
        .i_rdata    (i_imem_rdata),
        .o_wr       (pd_wr),
        .o_mask     (pd_mask),
        .o_redirect (pd_redirect),
        .o_target   (pd_target)
    );

    fe_instr_buffer #(
        .BUF_DEPTH   (BUF_DEPTH),
        .DEC_CREDITS (DEC_CREDITS)
    ) fe_instr_buffer_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_wr         (pd_wr),
        .i_pc         (fr_pc),
        .i_mask       (pd_mask),
        .i_rdata      (i_imem_rdata),
        .i_flush      (i_ex_redirect),   // resolved branch drains the queue
        .i_dec_credit (i_dec_credit),
        .o_pop_credit (pop_credit),
        .o_dec_valid  (o_dec_valid),
        .o_dec_pc     (o_dec_pc),
        .o_dec_mask   (o_dec_mask),
        .o_dec_instr0 (o_dec_instr0),
        .o_dec_instr1 (o_dec_instr1)
    );

endmodule

//--- rtl/fe_instr_buffer.sv
module fe_instr_buffer #(
    parameter int BUF_DEPTH   = 4,
    parameter int DEC_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_wr,
    input  fe_cfg_pkg::addr_t      i_pc,
    input  fe_cfg_pkg::slot_mask_t i_mask,
    input  fe_cfg_pkg::pair_data_t i_rdata,
    input  logic                   i_flush,
    input  logic                   i_dec_credit,
    output logic                   o_pop_credit,
    output logic                   o_dec_valid,
    output fe_cfg_pkg::addr_t      o_dec_pc,
    output fe_cfg_pkg::slot_mask_t o_dec_mask,
    output fe_cfg_pkg::instr_t     o_dec_instr0,
    output fe_cfg_pkg::instr_t     o_dec_instr1
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);
    localparam int DCR_W = $clog2(DEC_CREDITS + 1);

    fe_cfg_pkg::addr_t      pc_mem   [BUF_DEPTH];
    fe_cfg_pkg::slot_mask_t mask_mem [BUF_DEPTH];
    fe_cfg_pkg::pair_data_t data_mem [BUF_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [DCR_W-1:0] dec_credits;   // free slots on the decode side
    logic             xfer;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (i_wr) begin
            pc_mem[wr_ptr]   <= i_pc;
            mask_mem[wr_ptr] <= i_mask;
            data_mem[wr_ptr] <= i_rdata;
        end
    end

    ////////////////////
    // pointers and occupancy

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (xfer) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(i_wr) - CNT_W'(xfer);   // upstream credits stop overflow
        end
    end

    ////////////////////
    // decode side credits

    // decode still owns its slots across a flush
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            dec_credits <= DCR_W'(DEC_CREDITS);
        end else begin
            dec_credits <= dec_credits - DCR_W'(xfer) + DCR_W'(i_dec_credit);
        end
    end

    assign xfer         = (count != '0) && (dec_credits != '0);
    assign o_dec_valid  = xfer;
    assign o_pop_credit = xfer;    // freed slot goes back to the pc generator

    assign o_dec_pc     = pc_mem[rd_ptr];
    assign o_dec_mask   = mask_mem[rd_ptr];
    assign o_dec_instr0 = data_mem[rd_ptr][fe_cfg_pkg::INSTR_W-1:0];
    assign o_dec_instr1 = data_mem[rd_ptr][2*fe_cfg_pkg::INSTR_W-1:fe_cfg_pkg::INSTR_W];

endmodule

//--- rtl/fe_predecode.sv
module fe_predecode (
    input  logic                   i_valid,
    input  fe_cfg_pkg::addr_t      i_pc,
    input  fe_cfg_pkg::slot_mask_t i_mask,
    input  fe_cfg_pkg::pair_data_t i_rdata,
    output logic                   o_wr,
    output fe_cfg_pkg::slot_mask_t o_mask,
    output logic                   o_redirect,
    output fe_cfg_pkg::addr_t      o_target
);

    fe_cfg_pkg::instr_t instr0;
    fe_cfg_pkg::instr_t instr1;
    logic               br0;
    logic               br1;

    function automatic logic is_direct_br(input fe_cfg_pkg::instr_t instr);
        logic [la_isa_pkg::OPC_W-1:0] opc;
        opc = instr[la_isa_pkg::OPC_POS +: la_isa_pkg::OPC_W];
        return (opc == la_isa_pkg::OPC_B) || (opc == la_isa_pkg::OPC_BL);
    endfunction

    // sign extended byte offset from offs26 << 2
    function automatic fe_cfg_pkg::addr_t br_offset(input fe_cfg_pkg::instr_t instr);
        la_isa_pkg::offs_t offs;
        offs = {instr[la_isa_pkg::OFFS_HI_POS +: la_isa_pkg::OFFS_HI_W],
                instr[la_isa_pkg::OFFS_LO_POS +: la_isa_pkg::OFFS_LO_W]};
        return fe_cfg_pkg::addr_t'($signed({offs, 2'b00}));
    endfunction

    assign instr0 = i_rdata[fe_cfg_pkg::INSTR_W-1:0];
    assign instr1 = i_rdata[2*fe_cfg_pkg::INSTR_W-1:fe_cfg_pkg::INSTR_W];

    assign br0 = i_mask[0] && is_direct_br(instr0);
    assign br1 = i_mask[1] && is_direct_br(instr1);

    // slot 1 is dead after a taken slot 0 branch
    assign o_mask = br0 ? (i_mask & fe_cfg_pkg::slot_mask_t'(1)) : i_mask;

    always_comb begin
        if (br0) begin
            o_target = i_pc + br_offset(instr0);
        end else begin
            o_target = i_pc + fe_cfg_pkg::addr_t'(fe_cfg_pkg::INSTR_BYTES)
                       + br_offset(instr1);
        end
    end

    assign o_redirect = i_valid && (br0 || br1);
    assign o_wr       = i_valid;

endmodule

//--- rtl/fe_fetch_reg.sv
module fe_fetch_reg (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_req,
    input  fe_cfg_pkg::addr_t      i_fetch_pc,
    input  logic                   i_ex_redirect,
    input  logic                   i_pd_redirect,
    output logic                   o_valid,
    output fe_cfg_pkg::addr_t      o_pc,
    output fe_cfg_pkg::slot_mask_t o_mask,
    output logic                   o_squash
);

    localparam fe_cfg_pkg::addr_t ALIGN_MASK =
        ~fe_cfg_pkg::addr_t'(fe_cfg_pkg::PAIR_BYTES - 1);

    logic                   req_q;     // a response lands this cycle
    logic                   stale_q;   // redirect seen in the request cycle
    fe_cfg_pkg::addr_t      pc_q;      // aligned pair address
    fe_cfg_pkg::slot_mask_t mask_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            req_q   <= 1'b0;
            stale_q <= 1'b0;
        end else begin
            req_q   <= i_req;
            stale_q <= i_ex_redirect || i_pd_redirect;
        end
    end

    // payload moves with the request
    always_ff @(posedge clk) begin
        if (i_req) begin
            pc_q   <= i_fetch_pc & ALIGN_MASK;
            mask_q <= {1'b1, ~i_fetch_pc[2]};   // entry at slot 1 skips slot 0
        end
    end

    // a late redirect also kills the word arriving now
    assign o_valid  = req_q && !stale_q && !i_ex_redirect;
    assign o_squash = req_q && (stale_q || i_ex_redirect);
    assign o_pc     = pc_q;
    assign o_mask   = mask_q;

endmodule

//--- rtl/fe_pc_gen.sv
module fe_pc_gen #(
    parameter fe_cfg_pkg::addr_t RESET_PC = 32'h1c00_0000,
    parameter int BUF_DEPTH = 4
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_ex_redirect,
    input  fe_cfg_pkg::addr_t i_ex_target,
    input  logic              i_pd_redirect,
    input  fe_cfg_pkg::addr_t i_pd_target,
    input  logic              i_pop_credit,
    input  logic              i_squash,
    output logic              o_imem_req,
    output fe_cfg_pkg::addr_t o_imem_addr,
    output fe_cfg_pkg::addr_t o_fetch_pc
);

    localparam int CRED_W = $clog2(BUF_DEPTH + 1);
    localparam fe_cfg_pkg::addr_t ALIGN_MASK =
        ~fe_cfg_pkg::addr_t'(fe_cfg_pkg::PAIR_BYTES - 1);

    fe_cfg_pkg::addr_t fetch_pc;     // exact pc with bit 2 possibly set
    fe_cfg_pkg::addr_t pair_pc;
    logic [CRED_W-1:0] credits;
    logic              running;      // low for one cycle after reset

    assign pair_pc = fetch_pc & ALIGN_MASK;

    // old pc is dead in a redirect cycle
    assign o_imem_req  = running && (credits != '0) && !i_ex_redirect;
    assign o_imem_addr = pair_pc;
    assign o_fetch_pc  = fetch_pc;

    ////////////////////
    // fetch pc

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            running  <= 1'b0;
            fetch_pc <= RESET_PC;
        end else begin
            running <= 1'b1;
            if (i_ex_redirect) begin
                fetch_pc <= i_ex_target;            // resolved branch wins
            end else if (i_pd_redirect) begin
                fetch_pc <= i_pd_target;            // early b / bl
            end else if (o_imem_req) begin
                fetch_pc <= pair_pc + fe_cfg_pkg::addr_t'(fe_cfg_pkg::PAIR_BYTES);
            end
        end
    end

    ////////////////////
    // credits toward the instruction buffer

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            credits <= CRED_W'(BUF_DEPTH);
        end else if (i_ex_redirect) begin
            // buffer and fetch register drain in this same edge
            credits <= CRED_W'(BUF_DEPTH);
        end else begin
            credits <= credits + CRED_W'(i_pop_credit) + CRED_W'(i_squash)
                       - CRED_W'(o_imem_req);
        end
    end

endmodule

//--- rtl/la_isa_pkg.sv
package la_isa_pkg;

    ////////////////////
    // major opcode field

    localparam int OPC_POS = 26;   // opcode in bits 31..26
    localparam int OPC_W   = 6;

    localparam logic [OPC_W-1:0] OPC_B  = 6'b010100;   // b offs26
    localparam logic [OPC_W-1:0] OPC_BL = 6'b010101;   // bl offs26 links r1

    ////////////////////
    // 26-bit word offset, split in two pieces

    // low half sits above the high half in the word
    localparam int OFFS_LO_POS = 10;   // offs[15:0] in bits 25..10
    localparam int OFFS_LO_W   = 16;
    localparam int OFFS_HI_POS = 0;    // offs[25:16] in bits 9..0
    localparam int OFFS_HI_W   = 10;

    typedef logic [OFFS_HI_W+OFFS_LO_W-1:0] offs_t;

endpackage

//--- rtl/fe_cfg_pkg.sv
package fe_cfg_pkg;

    ////////////////////
    // basic widths

    localparam int ADDR_W  = 32;
    localparam int INSTR_W = 32;
    localparam int SLOTS   = 2;    // two words per fetch for dual issue

    ////////////////////
    // vector types

    typedef logic [ADDR_W-1:0]        addr_t;       // byte address
    typedef logic [INSTR_W-1:0]       instr_t;      // one instruction word
    typedef logic [SLOTS*INSTR_W-1:0] pair_data_t;  // slot 0 in the low word
    typedef logic [SLOTS-1:0]         slot_mask_t;  // bit 0 = slot 0

    ////////////////////
    // address steps

    localparam int INSTR_BYTES = INSTR_W / 8;
    localparam int PAIR_BYTES  = SLOTS * INSTR_BYTES;   // stride between fetched pairs

endpackage
